// File: build.f
rtl/renamePkg.sv
rtl/instrDecoder.sv
rtl/renameRegFile.sv
rtl/reservationStation.sv
rtl/resultBroadcast.sv
rtl/renameCore.sv
verification/tbRenameCore.sv

// File: verification/tbRenameCore.sv
module tbRenameCore;
    localparam int numStations = 4;
    localparam int waitLimit = 400;

    logic clk;
    logic rst;
    logic instrReq;
    renamePkg::instrWord instr;
    logic [3:0] pc;
    logic instrAck;
    renamePkg::resultBus result;
    logic [3:0] readAddr;
    logic [31:0] readData;

    logic [31:0] model [16];
    logic [31:0] expData [16];
    logic [3:0] expRd [16];
    int pending [16];
    logic [31:0] lfsr;
    logic [3:0] nextPc;
    int errorCount;
    int sentCount;
    int ackCount;
    int retiredCount;
    int lastInFlight;
    logic lastAck;
    logic lastReq;

    renameCore #(
        .numStations(numStations)
    ) renameCore_inst (
        .clk(clk),
        .rst(rst),
        .instrReq(instrReq),
        .instr(instr),
        .pc(pc),
        .instrAck(instrAck),
        .result(result),
        .readAddr(readAddr),
        .readData(readData)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic renamePkg::instrWord regInstr(input renamePkg::opKind op,
                                                     input logic [3:0] rd,
                                                     input logic [3:0] rs1,
                                                     input logic [3:0] rs2);
        renamePkg::instrWord w;
        w = '0;
        w.regForm.op = op;
        w.regForm.rd = rd;
        w.regForm.rs1 = rs1;
        w.regForm.rs2 = rs2;
        return w;
    endfunction

    function automatic renamePkg::instrWord immInstr(input logic [3:0] rd,
                                                     input logic [3:0] rs1, input int imm);
        renamePkg::instrWord w;
        w = '0;
        w.immForm.op = renamePkg::opAddi;
        w.immForm.rd = rd;
        w.immForm.rs1 = rs1;
        w.immForm.imm = imm[renamePkg::immW-1:0];
        return w;
    endfunction

    // Reference model, applied in program order
    // The result bus carries the computed value even when rd is register 0
    function automatic logic [31:0] applyInstr(input renamePkg::instrWord w);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        a = model[w.regForm.rs1];
        b = model[w.regForm.rs2];
        case (w.regForm.op)
            renamePkg::opAdd: v = a + b;
            renamePkg::opSub: v = a - b;
            renamePkg::opXor: v = a ^ b;
            default: v = a + {{(32 - renamePkg::immW){w.immForm.imm[renamePkg::immW-1]}},
                              w.immForm.imm};
        endcase
        model[w.regForm.rd] = v;
        model[0] = '0;
        return v;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            errorCount++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic abortRun(input string why);
        errorCount++;
        $display("%s", why);
        $display("Run ended: %0d retired, %0d errors", retiredCount, errorCount);
        $display("STATUS: FAIL");
        $finish;
    endtask

    task automatic waitAck(input logic level);
        int waited;
        waited = 0;
        while (instrAck !== level) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > waitLimit) begin
                abortRun($sformatf("Timed out waiting for instrAck=%0d at pc %0d",
                                   level, nextPc));
            end
        end
    endtask

    // Called one time unit after a rising edge
    task automatic sendInstr(input renamePkg::instrWord w);
        expData[nextPc] = applyInstr(w);
        expRd[nextPc] = w.regForm.rd;
        pending[nextPc]++;
        sentCount++;
        instr = w;
        pc = nextPc;
        instrReq = 1'b1;
        waitAck(1'b1);
        instrReq = 1'b0;
        waitAck(1'b0);
        nextPc++;
    endtask

    task automatic drainResults();
        int waited;
        waited = 0;
        while (retiredCount != sentCount) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > waitLimit) begin
                abortRun("Timed out waiting for outstanding results to retire");
            end
        end
        // One more edge so the last commit lands in the register file
        @(posedge clk);
        #1;
    endtask

    task automatic readReg(input logic [3:0] r);
        readAddr = r;
        @(negedge clk);
        checkValue($sformatf("readData[r%0d]", r), readData, model[r]);
        @(posedge clk);
        #1;
    endtask

    task automatic runRandomProgram(input int count);
        renamePkg::opKind op;
        logic [3:0] rd;
        logic [3:0] rs1;
        logic [3:0] rs2;
        logic [31:0] imm;
        for (int i = 0; i < count; i++) begin
            op = renamePkg::opKind'(randBits(2));
            rd = randBits(4);
            rs1 = randBits(4);
            if (op == renamePkg::opAddi) begin
                imm = randBits(renamePkg::immW);
                sendInstr(immInstr(rd, rs1, int'(imm)));
            end else begin
                rs2 = randBits(4);
                sendInstr(regInstr(op, rd, rs1, rs2));
            end
        end
    endtask

    // Handshake rules, station occupancy and result checks
    always @(negedge clk) begin : resultMonitor
        logic ackRise;
        logic ackFall;
        int inFlight;
        if (rst) begin
            lastAck = 1'b0;
            lastReq = 1'b0;
            lastInFlight = 0;
        end else begin
            ackRise = instrAck && !lastAck;
            ackFall = !instrAck && lastAck;
            if (ackRise && !lastReq) begin
                errorCount++;
                $display("instrAck rose although instrReq was low");
            end
            if (ackFall && lastReq) begin
                errorCount++;
                $display("instrAck fell while instrReq was still high");
            end
            if (ackRise && lastInFlight == numStations) begin
                errorCount++;
                $display("instrAck rose while every station was busy");
            end
            if (ackRise) begin
                ackCount++;
            end
            if (result.valid) begin
                if (result.tag == '0 || result.tag > numStations) begin
                    errorCount++;
                    $display("A result carried tag %0d, which no station owns", result.tag);
                end
                if (pending[result.pc] == 0) begin
                    errorCount++;
                    $display("A result for pc %0d arrived with nothing outstanding", result.pc);
                end else begin
                    checkValue("result.data", result.data, expData[result.pc]);
                    checkValue("result.rd", result.rd, expRd[result.pc]);
                    pending[result.pc]--;
                end
                retiredCount++;
            end
            // Acked but not yet retired equals the number of busy stations
            inFlight = ackCount - retiredCount;
            if (inFlight > numStations) begin
                errorCount++;
                $display("More instructions in flight than there are stations");
            end
            lastInFlight = inFlight;
            lastAck = instrAck;
            lastReq = instrReq;
        end
    end

    initial begin
        rst = 1'b1;
        instrReq = 1'b0;
        instr = '0;
        pc = '0;
        readAddr = '0;
        lfsr = 32'hf37b;
        nextPc = '0;
        errorCount = 0;
        sentCount = 0;
        ackCount = 0;
        retiredCount = 0;
        for (int i = 0; i < 16; i++) begin
            model[i] = '0;
            expData[i] = '0;
            expRd[i] = '0;
            pending[i] = 0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        checkValue("instrAck", instrAck, 32'h0);
        checkValue("result.valid", result.valid, 32'h0);

        // Independent registers, one negative immediate
        sendInstr(immInstr(4'd1, 4'd0, 1234));
        sendInstr(immInstr(4'd2, 4'd0, -77));
        sendInstr(immInstr(4'd3, 4'd0, 5000));
        drainResults();
        sendInstr(regInstr(renamePkg::opAdd, 4'd4, 4'd1, 4'd2));
        sendInstr(regInstr(renamePkg::opSub, 4'd5, 4'd1, 4'd3));
        sendInstr(regInstr(renamePkg::opXor, 4'd6, 4'd2, 4'd3));
        drainResults();

        // Dependent chain sent back to back
        sendInstr(regInstr(renamePkg::opAdd, 4'd7, 4'd4, 4'd5));
        sendInstr(regInstr(renamePkg::opSub, 4'd7, 4'd7, 4'd6));
        sendInstr(regInstr(renamePkg::opXor, 4'd8, 4'd7, 4'd1));
        sendInstr(immInstr(4'd8, 4'd8, -1));
        sendInstr(regInstr(renamePkg::opAdd, 4'd9, 4'd8, 4'd8));
        drainResults();

        // r10 gets written twice; the older writer waits on a chain
        sendInstr(regInstr(renamePkg::opAdd, 4'd12, 4'd1, 4'd2));
        sendInstr(regInstr(renamePkg::opAdd, 4'd12, 4'd12, 4'd12));
        sendInstr(regInstr(renamePkg::opAdd, 4'd10, 4'd12, 4'd1));
        sendInstr(immInstr(4'd10, 4'd0, 33));
        drainResults();
        readReg(4'd10);

        // Long dependent burst through the stations
        for (int i = 0; i < 8; i++) begin
            sendInstr(regInstr(renamePkg::opAdd, 4'd13, 4'd13, 4'd1));
        end
        drainResults();

        runRandomProgram(60);
        drainResults();
        for (int r = 0; r < 16; r++) begin
            readReg(4'(r));
        end
        readAddr = 4'd0;
        @(negedge clk);
        checkValue("readData[r0]", readData, 32'h0);

        for (int i = 0; i < 16; i++) begin
            if (pending[i] != 0) begin
                errorCount++;
                $display("pc %0d still has %0d results missing", i, pending[i]);
            end
        end
        checkValue("ackCount", ackCount, sentCount);
        $display("Run ended: %0d sent, %0d retired, %0d errors",
                 sentCount, retiredCount, errorCount);
        if (errorCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: rtl/renameCore.sv
module renameCore #(
    parameter int numStations = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic instrReq,
    input  renamePkg::instrWord instr,
    input  logic [renamePkg::pcW-1:0] pc,
    output logic instrAck,
    output renamePkg::resultBus result,
    input  logic [renamePkg::regAddrW-1:0] readAddr,
    output logic [renamePkg::dataW-1:0] readData
);
    logic [renamePkg::regAddrW-1:0] rs1Addr;
    logic [renamePkg::regAddrW-1:0] rs2Addr;
    logic [renamePkg::dataW-1:0] rs1Data;
    logic [renamePkg::dataW-1:0] rs2Data;
    logic [renamePkg::tagW-1:0] rs1Tag;
    logic [renamePkg::tagW-1:0] rs2Tag;
    logic renameEn;
    logic [renamePkg::regAddrW-1:0] renameRd;
    logic [renamePkg::tagW-1:0] renameTag;
    logic [numStations-1:0] stationBusy;
    logic [numStations-1:0] stationLoad;
    logic [numStations-1:0] stationReady;
    logic [numStations-1:0] grant;
    renamePkg::dispatchEntry entry;
    renamePkg::dispatchEntry issue [numStations];

    instrDecoder #(
        .numStations(numStations)
    ) instrDecoder_inst (
        .clk(clk),
        .rst(rst),
        .instrReq(instrReq),
        .instr(instr),
        .pc(pc),
        .instrAck(instrAck),
        .rs1Addr(rs1Addr),
        .rs2Addr(rs2Addr),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data),
        .rs1Tag(rs1Tag),
        .rs2Tag(rs2Tag),
        .renameEn(renameEn),
        .renameRd(renameRd),
        .renameTag(renameTag),
        .stationBusy(stationBusy),
        .stationLoad(stationLoad),
        .entry(entry),
        .result(result)
    );

    renameRegFile renameRegFile_inst (
        .clk(clk),
        .rst(rst),
        .rs1Addr(rs1Addr),
        .rs2Addr(rs2Addr),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data),
        .rs1Tag(rs1Tag),
        .rs2Tag(rs2Tag),
        .renameEn(renameEn),
        .renameRd(renameRd),
        .renameTag(renameTag),
        .result(result),
        .readAddr(readAddr),
        .readData(readData)
    );

    // Station i answers to tag i+1
    for (genvar i = 0; i < numStations; i++) begin : genStation
        reservationStation #(
            .myTag(renamePkg::tagW'(i + 1))
        ) reservationStation_inst (
            .clk(clk),
            .rst(rst),
            .load(stationLoad[i]),
            .entry(entry),
            .result(result),
            .grant(grant[i]),
            .busy(stationBusy[i]),
            .ready(stationReady[i]),
            .issue(issue[i])
        );
    end

    resultBroadcast #(
        .numStations(numStations)
    ) resultBroadcast_inst (
        .clk(clk),
        .rst(rst),
        .ready(stationReady),
        .issue(issue),
        .grant(grant),
        .result(result)
    );

endmodule

// File: rtl/resultBroadcast.sv
module resultBroadcast #(
    parameter int numStations = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic [numStations-1:0] ready,
    input  renamePkg::dispatchEntry issue [numStations],
    output logic [numStations-1:0] grant,
    output renamePkg::resultBus result
);
    renamePkg::dispatchEntry picked;
    logic [renamePkg::tagW-1:0] grantTag;
    logic [renamePkg::dataW-1:0] aluOut;

    // Fixed priority, lowest index first
    always_comb begin
        grant = '0;
        grantTag = '0;
        picked = issue[0];
        for (int i = numStations - 1; i >= 0; i--) begin
            if (ready[i]) begin
                grant = '0;
                grant[i] = 1'b1;
                grantTag = renamePkg::tagW'(i + 1);
                picked = issue[i];
            end
        end
    end

    always_comb begin
        case (picked.op)
            renamePkg::opSub: aluOut = picked.val1 - picked.val2;
            renamePkg::opXor: aluOut = picked.val1 ^ picked.val2;
            default: aluOut = picked.val1 + picked.val2;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= |grant;
        end
        result.tag <= grantTag;
        result.rd <= picked.rd;
        result.data <= aluOut;
        result.pc <= picked.pc;
    end

    grantOneHot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(grant)
    );

endmodule

// File: rtl/reservationStation.sv
module reservationStation #(
    parameter logic [renamePkg::tagW-1:0] myTag = 1
) (
    input  logic clk,
    input  logic rst,
    input  logic load,
    input  renamePkg::dispatchEntry entry,
    input  renamePkg::resultBus result,
    input  logic grant,
    output logic busy,
    output logic ready,
    output renamePkg::dispatchEntry issue
);
    renamePkg::dispatchEntry held;
    logic hit1;
    logic hit2;

    assign hit1 = result.valid && held.tag1 != '0 && result.tag == held.tag1;
    assign hit2 = result.valid && held.tag2 != '0 && result.tag == held.tag2;

    assign ready = busy && held.tag1 == '0 && held.tag2 == '0;
    assign issue = held;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (load) begin
            busy <= 1'b1;
        end else if (grant) begin
            busy <= 1'b0;
        end
    end

    // Operand capture while waiting on the result bus
    always_ff @(posedge clk) begin
        if (rst) begin
            held.tag1 <= '0;
            held.tag2 <= '0;
        end else if (load) begin
            held.tag1 <= entry.tag1;
            held.tag2 <= entry.tag2;
        end else begin
            if (hit1) begin
                held.tag1 <= '0;
            end
            if (hit2) begin
                held.tag2 <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            held.op <= entry.op;
            held.rd <= entry.rd;
            held.pc <= entry.pc;
            held.val1 <= entry.val1;
            held.val2 <= entry.val2;
        end else begin
            if (hit1) begin
                held.val1 <= result.data;
            end
            if (hit2) begin
                held.val2 <= result.data;
            end
        end
    end

    grantOnlyWhenReady: assert property (
        @(posedge clk) disable iff (rst)
        grant |-> ready
    );

    loadOnlyWhenFree: assert property (
        @(posedge clk) disable iff (rst)
        load |-> !busy
    );

    // The decoder bypass must never leave a new entry waiting on its own station
    noSelfWait: assert property (
        @(posedge clk) disable iff (rst)
        load |-> (entry.tag1 != myTag && entry.tag2 != myTag)
    );

endmodule

// File: rtl/renameRegFile.sv
module renameRegFile (
    input  logic clk,
    input  logic rst,
    input  logic [renamePkg::regAddrW-1:0] rs1Addr,
    input  logic [renamePkg::regAddrW-1:0] rs2Addr,
    output logic [renamePkg::dataW-1:0] rs1Data,
    output logic [renamePkg::dataW-1:0] rs2Data,
    output logic [renamePkg::tagW-1:0] rs1Tag,
    output logic [renamePkg::tagW-1:0] rs2Tag,
    input  logic renameEn,
    input  logic [renamePkg::regAddrW-1:0] renameRd,
    input  logic [renamePkg::tagW-1:0] renameTag,
    input  renamePkg::resultBus result,
    input  logic [renamePkg::regAddrW-1:0] readAddr,
    output logic [renamePkg::dataW-1:0] readData
);
    localparam int numRegs = 2 ** renamePkg::regAddrW;

    logic [renamePkg::dataW-1:0] regData [numRegs];
    logic [renamePkg::tagW-1:0] regTag [numRegs];
    logic commitHit;

    assign rs1Data = regData[rs1Addr];
    assign rs2Data = regData[rs2Addr];
    assign rs1Tag = regTag[rs1Addr];
    assign rs2Tag = regTag[rs2Addr];
    assign readData = regData[readAddr];

    // Only the newest writer of a register may update it
    assign commitHit = result.valid && regTag[result.rd] == result.tag;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < numRegs; i++) begin
                regData[i] <= '0;
                regTag[i] <= '0;
            end
        end else begin
            if (commitHit) begin
                regData[result.rd] <= result.data;
                regTag[result.rd] <= '0;
            end
            // Placed second so a same-cycle rename keeps its tag over the commit
            if (renameEn && renameRd != '0) begin
                regTag[renameRd] <= renameTag;
            end
        end
    end

    regZeroStaysZero: assert property (
        @(posedge clk) disable iff (rst)
        regTag[0] == '0 && regData[0] == '0
    );

endmodule

// File: rtl/instrDecoder.sv
module instrDecoder #(
    parameter int numStations = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic instrReq,
    input  renamePkg::instrWord instr,
    input  logic [renamePkg::pcW-1:0] pc,
    output logic instrAck,
    output logic [renamePkg::regAddrW-1:0] rs1Addr,
    output logic [renamePkg::regAddrW-1:0] rs2Addr,
    input  logic [renamePkg::dataW-1:0] rs1Data,
    input  logic [renamePkg::dataW-1:0] rs2Data,
    input  logic [renamePkg::tagW-1:0] rs1Tag,
    input  logic [renamePkg::tagW-1:0] rs2Tag,
    output logic renameEn,
    output logic [renamePkg::regAddrW-1:0] renameRd,
    output logic [renamePkg::tagW-1:0] renameTag,
    input  logic [numStations-1:0] stationBusy,
    output logic [numStations-1:0] stationLoad,
    output renamePkg::dispatchEntry entry,
    input  renamePkg::resultBus result
);
    renamePkg::opKind op;
    logic isImm;
    logic dispatch;
    logic [numStations-1:0] freeOneHot;
    logic [renamePkg::tagW-1:0] freeTag;
    logic [renamePkg::dataW-1:0] immExt;

    assign op = instr.regForm.op;
    assign isImm = (op == renamePkg::opAddi);
    assign rs1Addr = instr.regForm.rs1;
    assign rs2Addr = isImm ? '0 : instr.regForm.rs2;
    assign immExt = {{(renamePkg::dataW - renamePkg::immW){instr.immForm.imm[renamePkg::immW-1]}},
                     instr.immForm.imm};

    // Lowest free station wins, and its tag becomes the new name of rd
    always_comb begin
        freeOneHot = '0;
        freeTag = '0;
        for (int i = numStations - 1; i >= 0; i--) begin
            if (!stationBusy[i]) begin
                freeOneHot = '0;
                freeOneHot[i] = 1'b1;
                freeTag = renamePkg::tagW'(i + 1);
            end
        end
    end

    assign dispatch = instrReq && !instrAck && (freeOneHot != '0);
    assign stationLoad = dispatch ? freeOneHot : '0;
    assign renameEn = dispatch;
    assign renameRd = instr.regForm.rd;
    assign renameTag = freeTag;

    always_comb begin
        entry.op = op;
        entry.rd = instr.regForm.rd;
        entry.pc = pc;
        entry.val1 = rs1Data;
        entry.tag1 = rs1Tag;
        entry.val2 = rs2Data;
        entry.tag2 = rs2Tag;
        // A result on the bus this cycle is committed too late for the read port
        if (result.valid && rs1Tag != '0 && result.tag == rs1Tag) begin
            entry.val1 = result.data;
            entry.tag1 = '0;
        end
        if (isImm) begin
            entry.val2 = immExt;
            entry.tag2 = '0;
        end else if (result.valid && rs2Tag != '0 && result.tag == rs2Tag) begin
            entry.val2 = result.data;
            entry.tag2 = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            instrAck <= 1'b0;
        end else if (dispatch) begin
            instrAck <= 1'b1;
        end else if (!instrReq) begin
            instrAck <= 1'b0;
        end
    end

endmodule

// File: rtl/renamePkg.sv
package renamePkg;

    parameter int regAddrW = 4;
    parameter int dataW = 32;
    parameter int tagW = 3;
    parameter int pcW = 4;
    parameter int instrW = 24;
    parameter int immW = instrW - 2 - 2 * regAddrW;

    typedef enum logic [1:0] {
        opAdd,
        opSub,
        opXor,
        opAddi
    } opKind;

    typedef struct packed {
        opKind op;
        logic [regAddrW-1:0] rd;
        logic [regAddrW-1:0] rs1;
        logic [regAddrW-1:0] rs2;
        logic [immW-regAddrW-1:0] unused;
    } regFields;

    typedef struct packed {
        opKind op;
        logic [regAddrW-1:0] rd;
        logic [regAddrW-1:0] rs1;
        logic [immW-1:0] imm;
    } immFields;

    // The op field lines up in both forms and tells which one applies
    typedef union packed {
        regFields regForm;
        immFields immForm;
    } instrWord;

    // Tag 0 means the value is already present
    typedef struct packed {
        opKind op;
        logic [regAddrW-1:0] rd;
        logic [pcW-1:0] pc;
        logic [dataW-1:0] val1;
        logic [dataW-1:0] val2;
        logic [tagW-1:0] tag1;
        logic [tagW-1:0] tag2;
    } dispatchEntry;

    typedef struct packed {
        logic valid;
        logic [tagW-1:0] tag;
        logic [regAddrW-1:0] rd;
        logic [dataW-1:0] data;
        logic [pcW-1:0] pc;
    } resultBus;

endpackage
